//--- rvv_pkg.sv
package rvv_pkg;

	localparam int VLEN      = 128;
	localparam int VLENB     = VLEN / 8;
	localparam int NUM_VREGS = 32;

	typedef logic [VLEN-1:0]  vreg_t;
	typedef logic [VLENB-1:0] vbe_t;
	typedef logic [4:0]       vaddr_t;
	typedef logic [8:0]       vl_t;   // up to 128 elements
	typedef logic [2:0]       sew_t;  // 0 = e8, 1 = e16, 2 = e32

	// major opcodes
	localparam logic [6:0] OPC_OP_V     = 7'b1010111;
	localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
	localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

	localparam logic [2:0] F3_OPIVV = 3'b000;
	localparam logic [2:0] F3_OPIVX = 3'b100;
	localparam logic [2:0] F3_OPIVI = 3'b011;
	localparam logic [2:0] F3_OPCFG = 3'b111;

	localparam logic [5:0] F6_VMV = 6'b010111;

	localparam logic [31:0] VTYPE_ILL = 32'h8000_0000; // vill only

	// operand source of a vector move
	localparam logic [1:0] MV_SRC_V = 2'd0;
	localparam logic [1:0] MV_SRC_X = 2'd1;
	localparam logic [1:0] MV_SRC_I = 2'd2;

	// sequencer states shared by the lsu and the move unit
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_DONE
	} seq_state_t;

endpackage

//--- rvv_decode.sv
module rvv_decode import rvv_pkg::*; (
	input  logic [31:0] pcpi_insn_i,
	output logic        is_cfg_o,
	output logic        is_load_o,
	output logic        is_store_o,
	output logic        is_move_o,
	output logic        is_rvv_insn_o,
	output sew_t        mem_sew_o,
	output logic [1:0]  move_src_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [5:0] funct6;
	logic       mem_ok;

	assign opcode = pcpi_insn_i[6:0];
	assign funct3 = pcpi_insn_i[14:12];
	assign funct6 = pcpi_insn_i[31:26];

	always_comb begin
		is_cfg_o   = 1'b0;
		is_load_o  = 1'b0;
		is_store_o = 1'b0;
		is_move_o  = 1'b0;
		mem_sew_o  = '0;
		move_src_o = MV_SRC_V;
		mem_ok     = 1'b0;
		case (opcode)
			OPC_OP_V: begin
				if (funct3 == F3_OPCFG) begin
					// vsetvli, vsetivli, vsetvl
					is_cfg_o = ~pcpi_insn_i[31] || pcpi_insn_i[31:30] == 2'b11 ||
						pcpi_insn_i[31:25] == 7'b1000000;
				end else if (funct6 == F6_VMV && pcpi_insn_i[25] && pcpi_insn_i[24:20] == '0) begin
					case (funct3)
						F3_OPIVV: begin
							is_move_o  = 1'b1;
							move_src_o = MV_SRC_V;
						end
						F3_OPIVX: begin
							is_move_o  = 1'b1;
							move_src_o = MV_SRC_X;
						end
						F3_OPIVI: begin
							is_move_o  = 1'b1;
							move_src_o = MV_SRC_I;
						end
						default: ;
					endcase
				end
			end
			OPC_LOAD_FP, OPC_STORE_FP: begin
				// nf 0, mew 0, mop unit stride, vm set, lumop 0
				if (pcpi_insn_i[31:25] == 7'b0000001 && pcpi_insn_i[24:20] == '0) begin
					case (funct3)
						3'b000: begin
							mem_ok    = 1'b1;
							mem_sew_o = 3'd0;
						end
						3'b101: begin
							mem_ok    = 1'b1;
							mem_sew_o = 3'd1;
						end
						3'b110: begin
							mem_ok    = 1'b1;
							mem_sew_o = 3'd2;
						end
						default: ;
					endcase
				end
				is_load_o  = mem_ok && opcode == OPC_LOAD_FP;
				is_store_o = mem_ok && opcode == OPC_STORE_FP;
			end
			default: ;
		endcase
	end

	assign is_rvv_insn_o = is_cfg_o | is_load_o | is_store_o | is_move_o;

endmodule

//--- rvv_csr.sv
module rvv_csr import rvv_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        start_i,
	input  logic [31:0] pcpi_insn_i,
	input  logic [31:0] pcpi_rs1_i,
	input  logic [31:0] pcpi_rs2_i,
	output logic        ready_o,
	output logic        wr_o,
	output logic [31:0] rd_o,
	output vl_t         vl_o,
	output sew_t        vsew_o,
	output logic [1:0]  vlmul_o
);
	logic [31:0] vtype_q;
	vl_t         vl_q;
	logic [31:0] vtype_new;
	logic [31:0] avl;
	vl_t         vlmax;
	vl_t         vl_new;
	logic        is_vsetvli;
	logic        is_vsetivli;

	assign is_vsetvli  = ~pcpi_insn_i[31];
	assign is_vsetivli = pcpi_insn_i[31:30] == 2'b11;

	always_comb begin
		if (is_vsetvli)
			vtype_new = {21'b0, pcpi_insn_i[30:20]};
		else if (is_vsetivli)
			vtype_new = {22'b0, pcpi_insn_i[29:20]};
		else
			vtype_new = pcpi_rs2_i; // vsetvl

		// reserved bits, fractional lmul and e64 all end in vill
		if (vtype_new[31:8] != '0 || vtype_new[2] || vtype_new[5:3] > 3'd2)
			vlmax = '0;
		else
			vlmax = vl_t'(VLENB >> vtype_new[5:3]) << vtype_new[1:0];

		if (is_vsetivli)
			avl = {27'b0, pcpi_insn_i[19:15]};
		else if (pcpi_insn_i[19:15] != '0)
			avl = pcpi_rs1_i;
		else if (pcpi_insn_i[11:7] != '0)
			avl = '1;
		else
			avl = {23'b0, vl_q}; // keep vl

		if (vlmax == '0)
			vl_new = '0;
		else if (avl <= {23'b0, vlmax})
			vl_new = avl[8:0];
		else
			vl_new = vlmax;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_q <= VTYPE_ILL;
			vl_q    <= '0;
			ready_o <= 1'b0;
			wr_o    <= 1'b0;
			rd_o    <= '0;
		end else begin
			ready_o <= start_i;
			wr_o    <= start_i;
			rd_o    <= start_i ? {23'b0, vl_new} : '0;
			if (start_i) begin
				vtype_q <= (vlmax == '0) ? VTYPE_ILL : vtype_new;
				vl_q    <= vl_new;
			end
		end
	end

	assign vl_o    = vl_q;
	assign vsew_o  = vtype_q[5:3];
	assign vlmul_o = vtype_q[1:0];

endmodule

//--- rvv_vregs.sv
module rvv_vregs import rvv_pkg::*; (
	input  logic   clk,
	input  logic   we_i,
	input  vaddr_t waddr_i,
	input  vbe_t   wbe_i,
	input  vreg_t  wdata_i,
	input  vaddr_t raddr1_i,
	input  vaddr_t raddr2_i,
	output vreg_t  rdata1_o,
	output vreg_t  rdata2_o
);
	vreg_t regs [NUM_VREGS];

	// registers power up cleared
	initial begin
		for (int i = 0; i < NUM_VREGS; i++)
			regs[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (we_i) begin
			for (int b = 0; b < VLENB; b++)
				if (wbe_i[b])
					regs[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
		end
	end

	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

endmodule

//--- rvv_lsu.sv
module rvv_lsu import rvv_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        start_load_i,
	input  logic        start_store_i,
	input  logic [31:0] pcpi_insn_i,
	input  logic [31:0] pcpi_rs1_i,
	input  vl_t         vl_i,
	input  sew_t        mem_sew_i,
	input  logic        mem_ready_i,
	input  logic [31:0] mem_rdata_i,
	input  vreg_t       vreg_rdata_i,
	output logic        ready_o,
	output logic        wait_o,
	output logic        mem_valid_o,
	output logic        mem_we_o,
	output logic [31:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	output logic [3:0]  mem_wstrb_o,
	output vaddr_t      vreg_raddr_o,
	output logic        vreg_we_o,
	output vaddr_t      vreg_waddr_o,
	output vbe_t        vreg_wbe_o,
	output vreg_t       vreg_wdata_o
);
	seq_state_t  state;
	vl_t         idx;      // element counter
	logic        is_store;
	vaddr_t      vd;
	sew_t        sew;
	logic [31:0] base;

	logic        start;
	logic [7:0]  byte_off; // byte offset of the element within the group
	logic [31:0] elem_addr;
	logic [1:0]  lane;
	logic [3:0]  pos;
	logic [3:0]  emask;
	vaddr_t      cur_reg;
	vreg_t       rd_shift;
	logic [31:0] ld_word;

	assign start     = state == ST_IDLE && (start_load_i || start_store_i);
	assign byte_off  = 8'(idx) << sew;
	assign elem_addr = base + {24'b0, byte_off};
	assign lane      = elem_addr[1:0];
	assign pos       = byte_off[3:0];
	assign cur_reg   = vd + vaddr_t'(byte_off[7:4]);

	always_comb begin
		case (sew)
			3'd0:    emask = 4'b0001;
			3'd1:    emask = 4'b0011;
			default: emask = 4'b1111;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= (vl_i == '0) ? ST_DONE : ST_RUN;
						idx   <= '0;
					end
				end
				ST_RUN: begin
					if (mem_ready_i) begin
						if (idx == vl_i - 1'b1)
							state <= ST_DONE;
						idx <= idx + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			is_store <= start_store_i;
			vd       <= pcpi_insn_i[11:7];
			sew      <= mem_sew_i;
			base     <= pcpi_rs1_i & ~((32'd1 << mem_sew_i) - 32'd1); // align down
		end
	end

	assign ready_o     = state == ST_DONE;
	assign wait_o      = state == ST_RUN;
	assign mem_valid_o = state == ST_RUN;
	assign mem_we_o    = mem_valid_o && is_store;
	assign mem_addr_o  = {elem_addr[31:2], 2'b00};

	// store path moves element bytes onto their lane
	assign vreg_raddr_o = cur_reg;
	assign rd_shift     = vreg_rdata_i >> {pos, 3'b000};
	assign mem_wdata_o  = rd_shift[31:0] << {lane, 3'b000};
	assign mem_wstrb_o  = mem_we_o ? emask << lane : 4'b0000;

	// load path writes only this element's bytes
	assign ld_word      = mem_rdata_i >> {lane, 3'b000};
	assign vreg_we_o    = state == ST_RUN && mem_ready_i && !is_store;
	assign vreg_waddr_o = vreg_we_o ? cur_reg : '0;
	assign vreg_wbe_o   = vreg_we_o ? vbe_t'(emask) << pos : '0;
	assign vreg_wdata_o = vreg_we_o ? vreg_t'(ld_word) << {pos, 3'b000} : '0;

endmodule

//--- rvv_move.sv
module rvv_move import rvv_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        start_i,
	input  logic [31:0] pcpi_insn_i,
	input  logic [31:0] pcpi_rs1_i,
	input  logic [1:0]  move_src_i,
	input  vl_t         vl_i,
	input  sew_t        vsew_i,
	input  vreg_t       vreg_rdata_i,
	output logic        ready_o,
	output logic        wait_o,
	output vaddr_t      vreg_raddr_o,
	output logic        vreg_we_o,
	output vaddr_t      vreg_waddr_o,
	output vbe_t        vreg_wbe_o,
	output vreg_t       vreg_wdata_o
);
	seq_state_t  state;
	logic [2:0]  step;        // register within the group
	logic [10:0] total_bytes;
	logic [10:0] rem_bytes;
	logic        last_step;
	logic [31:0] scalar;
	vreg_t       splat;
	vbe_t        be;

	assign total_bytes = 11'(vl_i) << vsew_i;
	assign rem_bytes   = total_bytes - {4'b0, step, 4'b0};
	assign last_step   = rem_bytes <= 11'(VLENB);

	// simm5 is sign extended
	assign scalar = (move_src_i == MV_SRC_I) ?
		{{27{pcpi_insn_i[19]}}, pcpi_insn_i[19:15]} : pcpi_rs1_i;

	always_comb begin
		case (vsew_i)
			3'd0:    splat = {VLENB{scalar[7:0]}};
			3'd1:    splat = {(VLENB / 2){scalar[15:0]}};
			default: splat = {(VLENB / 4){scalar}};
		endcase
		if (rem_bytes >= 11'(VLENB))
			be = '1;
		else
			be = (vbe_t'(1) << rem_bytes[3:0]) - 1'b1; // tail bytes kept
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
			step  <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_i) begin
						state <= (vl_i == '0) ? ST_DONE : ST_RUN;
						step  <= '0;
					end
				end
				ST_RUN: begin
					if (last_step)
						state <= ST_DONE;
					step <= step + 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign ready_o = state == ST_DONE;
	assign wait_o  = state == ST_RUN || (state == ST_IDLE && start_i && vl_i != '0);

	assign vreg_raddr_o = pcpi_insn_i[19:15] + vaddr_t'(step); // vs1 of the group
	assign vreg_we_o    = state == ST_RUN;
	assign vreg_waddr_o = vreg_we_o ? pcpi_insn_i[11:7] + vaddr_t'(step) : '0;
	assign vreg_wbe_o   = vreg_we_o ? be : '0;
	assign vreg_wdata_o = !vreg_we_o ? '0 :
		(move_src_i == MV_SRC_V) ? vreg_rdata_i : splat;

endmodule

//--- rvv_pcpi_top.sv
module rvv_pcpi_top import rvv_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        pcpi_valid_i,
	input  logic [31:0] pcpi_insn_i,
	input  logic [31:0] pcpi_rs1_i,
	input  logic [31:0] pcpi_rs2_i,
	output logic        pcpi_ready_o,
	output logic        pcpi_wait_o,
	output logic        pcpi_wr_o,
	output logic [31:0] pcpi_rd_o,
	output logic        pcpi_is_rvv_insn_o,
	output logic        mem_valid_o,
	output logic        mem_we_o,
	output logic [31:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	output logic [3:0]  mem_wstrb_o,
	input  logic        mem_ready_i,
	input  logic [31:0] mem_rdata_i
);
	logic        run;
	logic        is_cfg, is_load, is_store, is_move;
	sew_t        mem_sew;
	logic [1:0]  move_src;
	logic        csr_ready, csr_wr;
	logic [31:0] csr_rd;
	vl_t         vl;
	sew_t        vsew;
	logic        lsu_ready, lsu_wait, lsu_we;
	vaddr_t      lsu_raddr, lsu_waddr;
	vbe_t        lsu_wbe;
	vreg_t       lsu_wdata;
	logic        mv_ready, mv_wait, mv_we;
	vaddr_t      mv_raddr, mv_waddr;
	vbe_t        mv_wbe;
	vreg_t       mv_wdata;
	vreg_t       rdata1, rdata2;

	assign run = pcpi_valid_i && !pcpi_ready_o; // no restart in the ready cycle

	rvv_decode u_decode (
		.pcpi_insn_i(pcpi_insn_i), .is_cfg_o(is_cfg), .is_load_o(is_load),
		.is_store_o(is_store), .is_move_o(is_move), .is_rvv_insn_o(pcpi_is_rvv_insn_o),
		.mem_sew_o(mem_sew), .move_src_o(move_src)
	);

	rvv_csr u_csr (
		.clk(clk), .resetn(resetn), .start_i(run && is_cfg), .pcpi_insn_i(pcpi_insn_i),
		.pcpi_rs1_i(pcpi_rs1_i), .pcpi_rs2_i(pcpi_rs2_i), .ready_o(csr_ready), .wr_o(csr_wr),
		.rd_o(csr_rd), .vl_o(vl), .vsew_o(vsew), .vlmul_o()
	);

	rvv_lsu u_lsu (
		.clk(clk), .resetn(resetn), .start_load_i(run && is_load),
		.start_store_i(run && is_store), .pcpi_insn_i(pcpi_insn_i), .pcpi_rs1_i(pcpi_rs1_i),
		.vl_i(vl), .mem_sew_i(mem_sew), .mem_ready_i(mem_ready_i), .mem_rdata_i(mem_rdata_i),
		.vreg_rdata_i(rdata1), .ready_o(lsu_ready), .wait_o(lsu_wait),
		.mem_valid_o(mem_valid_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o), .mem_wstrb_o(mem_wstrb_o), .vreg_raddr_o(lsu_raddr),
		.vreg_we_o(lsu_we), .vreg_waddr_o(lsu_waddr), .vreg_wbe_o(lsu_wbe),
		.vreg_wdata_o(lsu_wdata)
	);

	rvv_move u_move (
		.clk(clk), .resetn(resetn), .start_i(run && is_move),
		.pcpi_insn_i(pcpi_insn_i), .pcpi_rs1_i(pcpi_rs1_i), .move_src_i(move_src),
		.vl_i(vl), .vsew_i(vsew), .vreg_rdata_i(rdata2), .ready_o(mv_ready), .wait_o(mv_wait),
		.vreg_raddr_o(mv_raddr), .vreg_we_o(mv_we), .vreg_waddr_o(mv_waddr),
		.vreg_wbe_o(mv_wbe), .vreg_wdata_o(mv_wdata)
	);

	rvv_vregs u_vregs (
		.clk(clk), .we_i(lsu_we | mv_we), .waddr_i(lsu_waddr | mv_waddr),
		.wbe_i(lsu_wbe | mv_wbe), .wdata_i(lsu_wdata | mv_wdata), .raddr1_i(lsu_raddr),
		.raddr2_i(mv_raddr), .rdata1_o(rdata1), .rdata2_o(rdata2)
	);

	// idle units answer with zeros
	assign pcpi_ready_o = csr_ready | lsu_ready | mv_ready;
	assign pcpi_wait_o  = lsu_wait | mv_wait;
	assign pcpi_wr_o    = csr_wr;
	assign pcpi_rd_o    = csr_rd;

endmodule

//--- tb_mem_model.sv
module tb_mem_model (
	input  logic        clk,
	input  logic        resetn,
	input  logic        mem_valid_i,
	input  logic        mem_we_i,
	input  logic [31:0] mem_addr_i,
	input  logic [31:0] mem_wdata_i,
	input  logic [3:0]  mem_wstrb_i,
	output logic        mem_ready_o,
	output logic [31:0] mem_rdata_o
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] mem [1024];  // contents loaded by the testbench
	logic [9:0] word_addr;
	int         delay;

	assign word_addr   = {mem_addr_i[9:2], 2'b00};
	assign mem_rdata_o = {mem[word_addr + 3], mem[word_addr + 2],
		mem[word_addr + 1], mem[word_addr]};

	always @(posedge clk) begin
		if (!resetn) begin
			mem_ready_o <= 1'b0;
			delay = 0;
		end else if (mem_ready_o) begin
			mem_ready_o <= 1'b0;  // one cycle per request
		end else if (mem_valid_i) begin
			if (delay == 0) begin
				mem_ready_o <= 1'b1;
				delay = $urandom % 4;  // stall for the next request
				if (mem_we_i) begin
					for (int b = 0; b < 4; b++)
						if (mem_wstrb_i[b])
							mem[word_addr + 10'(b)] <= mem_wdata_i[b*8 +: 8];
				end
			end else begin
				delay = delay - 1;
			end
		end
	end

endmodule

//--- tb_rvv_top.sv
module tb_rvv_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CHK_NONE  = 0;
	localparam int CHK_SPLAT = 1;  // b holds the element value
	localparam int CHK_COPY  = 2;  // b is the destination of a

	typedef struct {
		logic [31:0] insn;
		logic [31:0] rs1;
		logic [31:0] rs2;
		logic [31:0] rd;
		logic        wr;
		int          nreq;
		int          chk;
		int          a;
		int          b;
		int          n;
		int          eb;
	} entry_t;

	logic        clk, resetn;
	logic        pcpi_valid, pcpi_ready, pcpi_wait, pcpi_wr, pcpi_is_rvv;
	logic [31:0] pcpi_insn, pcpi_rs1, pcpi_rs2, pcpi_rd;
	logic        mem_valid, mem_we, mem_ready;
	logic [31:0] mem_addr, mem_wdata, mem_rdata;
	logic [3:0]  mem_wstrb;
	entry_t      tbl[$];
	logic [7:0]  init_bytes [1024];  // memory contents before the run
	int          req_total = 0;
	int          cycles = 0;
	int          limit = 100000;
	int          errors = 0;

	rvv_pcpi_top DUT (
		.clk(clk), .resetn(resetn), .pcpi_valid_i(pcpi_valid), .pcpi_insn_i(pcpi_insn),
		.pcpi_rs1_i(pcpi_rs1), .pcpi_rs2_i(pcpi_rs2), .pcpi_ready_o(pcpi_ready),
		.pcpi_wait_o(pcpi_wait), .pcpi_wr_o(pcpi_wr), .pcpi_rd_o(pcpi_rd),
		.pcpi_is_rvv_insn_o(pcpi_is_rvv), .mem_valid_o(mem_valid), .mem_we_o(mem_we),
		.mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_wstrb_o(mem_wstrb),
		.mem_ready_i(mem_ready), .mem_rdata_i(mem_rdata)
	);

	tb_mem_model u_mem (
		.clk(clk), .resetn(resetn), .mem_valid_i(mem_valid), .mem_we_i(mem_we),
		.mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata), .mem_wstrb_i(mem_wstrb),
		.mem_ready_o(mem_ready), .mem_rdata_o(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (mem_valid && mem_ready)
			req_total = req_total + 1;  // completed memory requests
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout: the DUT did not finish within %0d cycles", limit);
			$display("** FAIL **");
			$fatal(1);
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	function automatic logic [2:0] width_code(input int sew);
		return (sew == 0) ? 3'b000 : (sew == 1) ? 3'b101 : 3'b110;
	endfunction

	function automatic logic [31:0] enc_vsetvli(input int rd, input int rs1, input int sew,
		input int lmul);
		return {1'b0, 5'b0, 3'(sew), 3'(lmul), 5'(rs1), 3'b111, 5'(rd), 7'h57};
	endfunction

	function automatic logic [31:0] enc_vsetivli(input int rd, input int uimm, input int sew,
		input int lmul);
		return {2'b11, 4'b0, 3'(sew), 3'(lmul), 5'(uimm), 3'b111, 5'(rd), 7'h57};
	endfunction

	function automatic logic [31:0] enc_vsetvl(input int rd, input int rs1, input int rs2);
		return {7'b1000000, 5'(rs2), 5'(rs1), 3'b111, 5'(rd), 7'h57};
	endfunction

	function automatic logic [31:0] enc_mem(input logic store, input int vd, input int sew);
		return {7'b0000001, 5'b0, 5'd10, width_code(sew), 5'(vd), store ? 7'h27 : 7'h07};
	endfunction

	// f3 picks vv, vx or vi; src is vs1, rs1 or simm5
	function automatic logic [31:0] enc_vmv(input logic [2:0] f3, input int vd, input int src);
		return {6'b010111, 1'b1, 5'b0, 5'(src), f3, 5'(vd), 7'h57};
	endfunction

	task automatic add(input logic [31:0] insn, input logic [31:0] rs1, input logic [31:0] rs2,
		input logic [31:0] rd, input logic wr, input int nreq, input int chk = CHK_NONE,
		input int a = 0, input int b = 0, input int n = 0, input int eb = 0);
		entry_t e;
		e = '{insn, rs1, rs2, rd, wr, nreq, chk, a, b, n, eb};
		tbl.push_back(e);
	endtask

	task automatic check_memory(input entry_t e);
		logic [7:0] exp;
		if (e.chk == CHK_SPLAT) begin
			for (int i = 0; i < e.n * e.eb; i++) begin
				exp = 8'(e.b >> (8 * (i % e.eb)));
				check($sformatf("mem[0x%03h]", e.a + i), 32'(u_mem.mem[e.a + i]), 32'(exp));
			end
			check("mem past splat", 32'(u_mem.mem[e.a + e.n * e.eb]),
				32'(init_bytes[e.a + e.n * e.eb]));
		end else if (e.chk == CHK_COPY) begin
			for (int i = 0; i < e.n; i++)
				check($sformatf("mem[0x%03h]", e.b + i), 32'(u_mem.mem[e.b + i]),
					32'(init_bytes[e.a + i]));
			check("mem past copy", 32'(u_mem.mem[e.b + e.n]), 32'(init_bytes[e.b + e.n]));
		end
	endtask

	task automatic apply(input int k);
		entry_t e;
		int     req0;
		e = tbl[k];
		req0 = req_total;
		pcpi_insn  = e.insn;
		pcpi_rs1   = e.rs1;
		pcpi_rs2   = e.rs2;
		pcpi_valid = 1'b1;
		do begin
			@(posedge clk);
			#1;
			check("pcpi_is_rvv_insn", 32'(pcpi_is_rvv), 32'd1);
			if (!pcpi_ready)
				check("pcpi_wait", 32'(pcpi_wait), 32'd1);  // busy until ready
		end while (!pcpi_ready);
		check($sformatf("pcpi_rd (row %0d)", k), pcpi_rd, e.rd);
		check($sformatf("pcpi_wr (row %0d)", k), 32'(pcpi_wr), 32'(e.wr));
		check($sformatf("mem requests (row %0d)", k), 32'(req_total - req0), 32'(e.nreq));
		pcpi_valid = 1'b0;
		pcpi_insn  = '0;
		check_memory(e);
		@(posedge clk);
		#1;
	endtask

	initial begin
		pcpi_valid = 1'b0;
		pcpi_insn  = '0;
		pcpi_rs1   = '0;
		pcpi_rs2   = '0;
		resetn     = 1'b0;
		void'($urandom(32'h38d5_8153));
		for (int a = 0; a < 1024; a++)
			init_bytes[a] = 8'(a) ^ (8'(a >> 8) * 8'h47);
		for (int a = 'h200; a < 'h400; a++)
			init_bytes[a] = 8'($urandom);  // random source data
		for (int a = 0; a < 1024; a++)
			u_mem.mem[a] = init_bytes[a];

		add(enc_mem(0, 0, 0), 32'h100, 0, 0, 0, 0);                // vl 0 after reset
		add(enc_vsetvli(1, 1, 0, 0), 10, 0, 10, 1, 0);              // e8 m1 has vlmax 16
		add(enc_vsetvli(1, 1, 2, 3), 100, 0, 32, 1, 0);             // e32 m8 has vlmax 32
		add(enc_vsetvli(1, 1, 0, 5), 4, 0, 0, 1, 0);                // mf8 is vill
		add(enc_vsetivli(1, 5, 3, 0), 0, 0, 0, 1, 0);               // e64 is vill
		add(enc_vsetvl(1, 1, 2), 7, 32'h09, 7, 1, 0);               // e16 m2 from rs2
		add(enc_vsetvli(0, 0, 1, 1), 0, 0, 7, 1, 0);                // keeps vl
		add(enc_vsetivli(1, 13, 1, 1), 0, 0, 13, 1, 0);
		add(enc_vmv(3'b100, 8, 3), 32'h1234_abcd, 0, 0, 0, 0);
		add(enc_mem(1, 8, 1), 32'h100, 0, 0, 0, 13, CHK_SPLAT, 'h100, 'habcd, 13, 2);
		add(enc_vsetivli(1, 9, 0, 0), 0, 0, 9, 1, 0);
		add(enc_vmv(3'b011, 4, 5'b11101), 0, 0, 0, 0, 0);           // simm5 -3
		add(enc_mem(1, 4, 0), 32'h180, 0, 0, 0, 9, CHK_SPLAT, 'h180, 'hfd, 9, 1);
		// round trips with lmul 2
		add(enc_vsetvli(1, 1, 0, 1), 1000, 0, 32, 1, 0);
		add(enc_mem(0, 16, 0), 32'h200, 0, 0, 0, 32);
		add(enc_mem(1, 16, 0), 32'h280, 0, 0, 0, 32, CHK_COPY, 'h200, 'h280, 32);
		add(enc_vsetvli(1, 1, 1, 1), 1000, 0, 16, 1, 0);
		add(enc_mem(0, 16, 1), 32'h300, 0, 0, 0, 16);
		add(enc_mem(1, 16, 1), 32'h340, 0, 0, 0, 16, CHK_COPY, 'h300, 'h340, 32);
		add(enc_vsetvli(1, 1, 2, 1), 1000, 0, 8, 1, 0);
		add(enc_mem(0, 16, 2), 32'h380, 0, 0, 0, 8);
		add(enc_mem(1, 16, 2), 32'h3c0, 0, 0, 0, 8, CHK_COPY, 'h380, 'h3c0, 32);
		add(enc_vmv(3'b000, 24, 16), 0, 0, 0, 0, 0);                // group copy
		add(enc_mem(1, 24, 2), 32'h040, 0, 0, 0, 8, CHK_COPY, 'h380, 'h040, 32);
		limit = (tbl.size() + 1) * 200;

		repeat (5) @(posedge clk);
		#1;
		resetn    = 1'b1;
		pcpi_insn = 32'h0000_0013;  // addi is not a vector instruction
		@(posedge clk);
		#1;
		check("pcpi_ready", 32'(pcpi_ready), 32'd0);
		check("pcpi_wait", 32'(pcpi_wait), 32'd0);
		check("pcpi_wr", 32'(pcpi_wr), 32'd0);
		check("mem_valid", 32'(mem_valid), 32'd0);
		check("pcpi_is_rvv_insn", 32'(pcpi_is_rvv), 32'd0);

		foreach (tbl[k])
			apply(k);

		if (errors == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("** FAIL **");
			$fatal(1);
		end
	end

endmodule

//--- verilog.f
rvv_pkg.sv
rvv_decode.sv
rvv_csr.sv
rvv_vregs.sv
rvv_lsu.sv
rvv_move.sv
rvv_pcpi_top.sv
tb_mem_model.sv
tb_rvv_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rvv_top -f verilog.f \
	-o tb_rvv_top > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/tb_rvv_top > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qF "** PASS **" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
